// File: design/comtest_pkg.sv
package comtest_pkg;

	typedef logic [7:0]  byte_t;   // one received data byte
	typedef logic [3:0]  nibble_t; // one hex digit
	typedef logic [6:0]  seg_t;    // segments a..g, bit 0 is a, active high
	typedef logic [15:0] led_t;    // board led word

	// clocks per serial bit, 50 MHz board clock at 115200 baud
	localparam logic [15:0] CLKS_PER_BIT_DEFAULT = 16'd434;

	// hex digit to segment lines, bit order g f e d c b a
	function automatic seg_t seg_pattern(input nibble_t digit);
		case (digit)
			4'h0: seg_pattern = 7'h3f;
			4'h1: seg_pattern = 7'h06; // b c only
			4'h2: seg_pattern = 7'h5b;
			4'h3: seg_pattern = 7'h4f;
			4'h4: seg_pattern = 7'h66;
			4'h5: seg_pattern = 7'h6d;
			4'h6: seg_pattern = 7'h7d; // top bar set, keeps 6 apart from b
			4'h7: seg_pattern = 7'h07;
			4'h8: seg_pattern = 7'h7f; // all on
			4'h9: seg_pattern = 7'h6f;
			4'ha: seg_pattern = 7'h77;
			4'hb: seg_pattern = 7'h7c; // lower case b
			4'hc: seg_pattern = 7'h39;
			4'hd: seg_pattern = 7'h5e; // lower case d, no top bar unlike 0
			4'he: seg_pattern = 7'h79;
			default: seg_pattern = 7'h71; // f
		endcase
	endfunction

endpackage

// File: design/digseg_driver.sv
module digseg_driver
	import comtest_pkg::*;
(
	input  nibble_t data, // hex digit to show
	output seg_t    seg   // segments a..g, active high
);

	// segment layout, bit index in brackets
	//
	//    --a[0]--
	//   |        |
	//  f[5]     b[1]
	//   |        |
	//    --g[6]--
	//   |        |
	//  e[4]     c[2]
	//   |        |
	//    --d[3]--

	seg_t pattern; // decoded digit

	always_comb begin
		pattern = seg_pattern(data); // all sixteen digits covered
	end

	assign seg = pattern; // straight to the segment pins

endmodule

// File: design/uart_receiver.sv
module uart_receiver
	import comtest_pkg::*;
#(
	parameter logic [15:0] CLKS_PER_BIT = CLKS_PER_BIT_DEFAULT // must be 4 or more
) (
	input  logic  clk,
	input  logic  rst,        // sync, active low
	input  logic  rxd,        // async serial line, idles high
	output byte_t rx_data,    // last good byte, held until next frame
	output logic  rx_ready,   // one clock per good frame
	output logic  rx_waiting  // idle, hunting for a start bit
);

	// 8N1 receiver, every bit sampled in its middle

	localparam logic [15:0] HALF_LAST = CLKS_PER_BIT / 16'd2 - 16'd1; // mid of start bit
	localparam logic [15:0] FULL_LAST = CLKS_PER_BIT - 16'd1;         // one whole bit

	typedef enum logic [2:0] {
		ST_WAITING,  // line idle, watch for falling edge
		ST_START,    // qualify start bit at half a bit time
		ST_DATA,     // eight data bits, lsb first
		ST_STOP,     // check stop bit
		ST_RECOVER   // end of frame, wait for line high
	} rx_state_t;

	rx_state_t   state;
	logic        rxd_meta;    // first sync stage
	logic        rxd_sync;    // second sync stage, used everywhere below
	logic [15:0] bit_cnt;     // clocks within current bit
	logic [2:0]  bit_idx;     // data bit being received
	byte_t       shift_reg;   // data bits collected so far
	logic        bit_done;    // bit_cnt at end of a bit period
	logic        start_mid;   // middle of start bit reached
	logic        data_sample; // middle of a data bit reached
	logic        stop_sample; // middle of stop bit reached

	// two flops against metastability, reset to idle level
	always_ff @(posedge clk) begin
		if (!rst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	assign bit_done    = (bit_cnt == FULL_LAST);
	assign start_mid   = (state == ST_START) && (bit_cnt == HALF_LAST);
	assign data_sample = (state == ST_DATA) && bit_done;
	assign stop_sample = (state == ST_STOP) && bit_done;

	// control fsm and bit timing
	always_ff @(posedge clk) begin
		if (!rst) begin
			state    <= ST_WAITING;
			bit_cnt  <= 16'd0;
			bit_idx  <= 3'd0;
			rx_ready <= 1'b0;
		end else begin
			rx_ready <= 1'b0; // pulse by default
			case (state)
				ST_WAITING: begin
					bit_cnt <= 16'd0;
					if (!rxd_sync)
						state <= ST_START; // falling edge seen
				end
				ST_START: begin
					if (start_mid) begin
						bit_cnt <= 16'd0;
						bit_idx <= 3'd0;
						// still low at half bit, else it was a glitch
						state <= rxd_sync ? ST_WAITING : ST_DATA;
					end else begin
						bit_cnt <= bit_cnt + 16'd1;
					end
				end
				ST_DATA: begin
					if (data_sample) begin
						bit_cnt <= 16'd0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= ST_STOP; // last data bit taken
					end else begin
						bit_cnt <= bit_cnt + 16'd1;
					end
				end
				ST_STOP: begin
					if (stop_sample) begin
						bit_cnt <= 16'd0;
						state   <= ST_RECOVER; // pulse cycle is not yet waiting
						if (rxd_sync)
							rx_ready <= 1'b1; // good frame
						// low stop bit is a framing error, byte dropped
					end else begin
						bit_cnt <= bit_cnt + 16'd1;
					end
				end
				ST_RECOVER: begin
					bit_cnt <= 16'd0;
					if (rxd_sync)
						state <= ST_WAITING; // line back to idle
				end
				default: state <= ST_WAITING;
			endcase
		end
	end

	// data path, lsb arrives first so shift toward bit 0
	always_ff @(posedge clk) begin
		if (data_sample)
			shift_reg <= {rxd_sync, shift_reg[7:1]};
		if (stop_sample && rxd_sync)
			rx_data <= shift_reg; // only good frames reach the output
	end

	// start qualification still counts as looking for a start bit
	assign rx_waiting = (state == ST_WAITING) || (state == ST_START);

endmodule

// File: design/comtest.sv
module comtest
	import comtest_pkg::*;
(
	input  logic       clk,
	input  logic       rst,        // sync, active low
	input  byte_t      rx_data,    // valid while rx_ready is high
	input  logic       rx_ready,   // one pulse per good frame
	input  logic       rx_waiting, // receiver idle
	output logic [7:0] frame_num,  // frames received, modulo 256
	output led_t       led         // status word for the board leds
);

	// frame monitor, counts good frames and keeps the last byte

	nibble_t cnt_low;   // low hex digit of frame count
	nibble_t cnt_high;  // high hex digit of frame count
	byte_t   last_byte; // byte of the most recent good frame
	logic    low_wrap;  // low digit rolls over on this frame

	assign low_wrap = (cnt_low == 4'hf);

	// count kept as two digits, one per display
	always_ff @(posedge clk) begin
		if (!rst) begin
			cnt_low  <= 4'h0;
			cnt_high <= 4'h0;
		end else if (rx_ready) begin
			cnt_low <= cnt_low + 4'h1; // wraps f to 0 by itself
			if (low_wrap)
				cnt_high <= cnt_high + 4'h1; // carry, ff wraps to 00
		end
	end

	// last byte is cleared so the leds start dark
	always_ff @(posedge clk) begin
		if (!rst)
			last_byte <= 8'h00;
		else if (rx_ready)
			last_byte <= rx_data; // rx_data holds, latch on the pulse
	end

	assign frame_num = {cnt_high, cnt_low};

	// led word
	//   15..8  last good byte
	//    7..2  unused, zero
	//    1     rx_ready, live
	//    0     rx_waiting, live
	assign led = {last_byte, 6'b00_0000, rx_ready, rx_waiting};

endmodule

// File: design/board_top.sv
module board_top
	import comtest_pkg::*;
#(
	parameter logic [15:0] CLKS_PER_BIT = CLKS_PER_BIT_DEFAULT // at least 4
) (
	input  logic clk,
	input  logic rst,      // sync, active low, straight from the board button
	input  logic rxd,      // serial input from the host
	output seg_t segdisp0, // low hex digit of frame count
	output seg_t segdisp1, // high hex digit of frame count
	output led_t led       // last byte and receiver flags
);

	// serial bring-up board: receiver, frame monitor, two digit displays

	byte_t      rx_data;    // received byte
	logic       rx_ready;   // good frame pulse
	logic       rx_waiting; // receiver idle
	logic [7:0] frame_num;  // frame count, two hex digits

	// receiver runs always enabled off the board reset
	uart_receiver #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uart_rx (
		.clk        (clk),
		.rst        (rst),
		.rxd        (rxd),
		.rx_data    (rx_data),
		.rx_ready   (rx_ready),
		.rx_waiting (rx_waiting)
	);

	comtest monitor (
		.clk        (clk),
		.rst        (rst),
		.rx_data    (rx_data),
		.rx_ready   (rx_ready),
		.rx_waiting (rx_waiting),
		.frame_num  (frame_num),
		.led        (led)
	);

	// left display, upper nibble
	digseg_driver data_disp_high (
		.data (frame_num[7:4]),
		.seg  (segdisp1)
	);

	// right display, lower nibble
	digseg_driver data_disp_low (
		.data (frame_num[3:0]),
		.seg  (segdisp0)
	);

endmodule

// File: sim/board_asserts.sv
module board_asserts
	import comtest_pkg::*;
(
	input logic       clk,
	input logic       rst,        // sync, active low
	input logic       rx_ready,
	input logic       rx_waiting,
	input logic [7:0] frame_num,
	input led_t       led
);

	int fail_count = 0; // read by the testbench at the end

	// good frame pulse is one clock wide
	a_ready_single: assert property (@(posedge clk) disable iff (!rst)
		rx_ready |=> !rx_ready)
		else begin fail_count++; $error("rx_ready high for two cycles"); end

	// receiver is never idle in the pulse cycle
	a_ready_not_waiting: assert property (@(posedge clk) disable iff (!rst)
		!(rx_ready && rx_waiting))
		else begin fail_count++; $error("rx_ready and rx_waiting high together"); end

	a_led_unused: assert property (@(posedge clk) disable iff (!rst)
		led[7:2] == 6'b00_0000)
		else begin fail_count++; $error("led bits 7 to 2 not zero"); end

	// count steps by one the clock after a pulse, holds otherwise
	a_count_step: assert property (@(posedge clk) disable iff (!rst)
		frame_num == ($past(rx_ready) ? 8'($past(frame_num) + 8'd1) : $past(frame_num)))
		else begin fail_count++; $error("frame_num step wrong"); end

endmodule

bind board_top board_asserts asserts0 (
	.clk        (clk),
	.rst        (rst),
	.rx_ready   (rx_ready),
	.rx_waiting (rx_waiting),
	.frame_num  (frame_num),
	.led        (led)
);

// File: sim/board_tb.sv
module board_tb
	import comtest_pkg::*;
();

	localparam int BIT_CLKS      = 16;           // short bit time keeps the run fast
	localparam int KIND_GOOD     = 0;            // frame with a high stop bit
	localparam int KIND_BAD_STOP = 1;            // frame with a low stop bit
	localparam int KIND_GLITCH   = 2;            // start edge shorter than half a bit
	localparam int SETTLE_LIMIT  = 4 * BIT_CLKS; // clocks allowed to reach waiting again
	localparam int CHECK_LIMIT   = 8;            // clocks allowed for one compare

	// segment lines, bit 0 is segment a
	localparam seg_t SEG_A = 7'b000_0001;
	localparam seg_t SEG_B = 7'b000_0010;
	localparam seg_t SEG_C = 7'b000_0100;
	localparam seg_t SEG_D = 7'b000_1000;
	localparam seg_t SEG_E = 7'b001_0000;
	localparam seg_t SEG_F = 7'b010_0000;
	localparam seg_t SEG_G = 7'b100_0000;

	logic  clk;
	logic  rst;
	logic  rxd;
	seg_t  segdisp0;
	seg_t  segdisp1;
	led_t  led;

	logic [31:0] rng_state = 32'h83ac_5833; // xorshift state
	int          req_cnt   = 0;             // checks asked for by the stimulus
	int          done_cnt  = 0;             // checks finished by the compare process
	int          frame_kind[$];             // every frame sent, in order
	byte_t       frame_byte[$];             // data byte of each frame sent
	logic [15:0] seen_low  = 16'h0000;      // digits shown on segdisp0
	logic [15:0] seen_high = 16'h0000;      // digits shown on segdisp1
	byte_t       pulse_cnt = 8'h00;         // ready pulses seen on led[1], modulo 256

	board_top #(
		.CLKS_PER_BIT (16'(BIT_CLKS))
	) dut0 (
		.clk      (clk),
		.rst      (rst),
		.rxd      (rxd),
		.segdisp0 (segdisp0),
		.segdisp1 (segdisp1),
		.led      (led)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // period 8
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// hex digit to lit segments, lower case b and d
	function automatic seg_t digit_segments(input nibble_t d);
		case (d)
			4'h0: return SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F;
			4'h1: return SEG_B | SEG_C;
			4'h2: return SEG_A | SEG_B | SEG_D | SEG_E | SEG_G;
			4'h3: return SEG_A | SEG_B | SEG_C | SEG_D | SEG_G;
			4'h4: return SEG_B | SEG_C | SEG_F | SEG_G;
			4'h5: return SEG_A | SEG_C | SEG_D | SEG_F | SEG_G;
			4'h6: return SEG_A | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
			4'h7: return SEG_A | SEG_B | SEG_C;
			4'h8: return SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
			4'h9: return SEG_A | SEG_B | SEG_C | SEG_D | SEG_F | SEG_G;
			4'ha: return SEG_A | SEG_B | SEG_C | SEG_E | SEG_F | SEG_G;
			4'hb: return SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
			4'hc: return SEG_A | SEG_D | SEG_E | SEG_F;
			4'hd: return SEG_B | SEG_C | SEG_D | SEG_E | SEG_G;
			4'he: return SEG_A | SEG_D | SEG_E | SEG_F | SEG_G;
			default: return SEG_A | SEG_E | SEG_F | SEG_G;
		endcase
	endfunction

	// reference model, replays the frame list from reset
	function automatic void model_frames(output byte_t cnt, output byte_t last,
			output led_t led_exp, output seg_t seg_lo, output seg_t seg_hi);
		int i;
		cnt  = 8'h00;
		last = 8'h00;
		for (i = 0; i < frame_kind.size(); i++) begin
			if (frame_kind[i] == KIND_GOOD) begin
				cnt  = cnt + 8'h01; // modulo 256 by width
				last = frame_byte[i];
			end
		end
		led_exp = {last, 8'h01}; // settled: ready low, waiting high
		seg_lo  = digit_segments(cnt[3:0]);
		seg_hi  = digit_segments(cnt[7:4]);
	endfunction

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %h got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_seg(input string name, input seg_t exp, input seg_t act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %b got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_led(input string name, input led_t exp, input led_t act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %h got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	// drive rxd for a number of clocks
	task automatic hold_line(input logic level, input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(posedge clk);
			rxd <= level;
		end
	endtask

	// 8N1 frame, lsb first
	task automatic send_frame(input byte_t data, input logic stop_level);
		int i;
		hold_line(1'b0, BIT_CLKS); // start bit
		for (i = 0; i < 8; i++)
			hold_line(data[i], BIT_CLKS);
		hold_line(stop_level, BIT_CLKS);
		hold_line(1'b1, 1); // back to idle
	endtask

	task automatic send_glitch(input int len);
		hold_line(1'b0, len);
		hold_line(1'b1, BIT_CLKS); // lets start qualification run out
	endtask

	task automatic wait_settled();
		int n;
		n = 0;
		while ((led[0] !== 1'b1 || led[1] !== 1'b0) && n < SETTLE_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (n >= SETTLE_LIMIT) begin
			$display("timeout: the receiver never returned to waiting");
			abort_run();
		end
	endtask

	task automatic request_check();
		int n;
		wait_settled();
		req_cnt <= req_cnt + 1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (done_cnt != req_cnt && n < CHECK_LIMIT);
		if (done_cnt != req_cnt) begin
			$display("timeout: the compare process never took the check request");
			abort_run();
		end
	endtask

	task automatic run_frame(input int kind, input byte_t data, input int glitch_len);
		case (kind)
			KIND_GOOD:     send_frame(data, 1'b1);
			KIND_BAD_STOP: send_frame(data, 1'b0);
			default:       send_glitch(glitch_len);
		endcase
		frame_kind.push_back(kind);
		frame_byte.push_back(data);
		request_check();
	endtask

	// every good frame shows one clock on the ready led
	always @(posedge clk) begin : pulse_count
		if (led[1] === 1'b1)
			pulse_cnt <= pulse_cnt + 8'h01;
	end

	// compare process, one full check per request
	always @(posedge clk) begin : compare
		byte_t cnt_exp;
		byte_t last_exp;
		led_t  led_exp;
		seg_t  lo_exp;
		seg_t  hi_exp;
		if (done_cnt != req_cnt) begin
			model_frames(cnt_exp, last_exp, led_exp, lo_exp, hi_exp);
			check_byte("frame_num", cnt_exp, dut0.frame_num);
			check_byte("led[1] pulses", cnt_exp, pulse_cnt);
			check_byte("led[15:8]", last_exp, led[15:8]);
			check_led("led", led_exp, led);
			check_seg("segdisp0", lo_exp, segdisp0);
			check_seg("segdisp1", hi_exp, segdisp1);
			seen_low[cnt_exp[3:0]]  <= 1'b1;
			seen_high[cnt_exp[7:4]] <= 1'b1;
			done_cnt <= done_cnt + 1;
		end
	end

	initial begin : stimulus
		int          i;
		int          kind;
		int          gap;
		logic [31:0] r;
		rst <= 1'b0;
		rxd <= 1'b1; // idle line
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		request_check(); // reset state, count 0 and only the waiting led

		for (i = 0; i < 8; i++) begin
			r = next_random();
			run_frame(KIND_GOOD, r[7:0], 0);
		end

		// framing errors, the second one holds the line low for ten bits
		r = next_random();
		run_frame(KIND_BAD_STOP, r[7:0], 0);
		run_frame(KIND_GOOD, r[15:8], 0);
		run_frame(KIND_BAD_STOP, 8'h00, 0);
		run_frame(KIND_GOOD, r[23:16], 0);

		for (i = 1; i <= 5; i++)
			run_frame(KIND_GLITCH, 8'h00, i); // all under half a bit
		r = next_random();
		run_frame(KIND_GOOD, r[7:0], 0);

		// past 256 frames, count wraps and both digits cycle
		for (i = 0; i < 300; i++) begin
			r = next_random();
			run_frame(KIND_GOOD, r[7:0], 0);
		end

		// random mix with idle gaps
		for (i = 0; i < 300; i++) begin
			r = next_random();
			if (r[2:0] == 3'd6)
				kind = KIND_BAD_STOP;
			else if (r[2:0] == 3'd7)
				kind = KIND_GLITCH;
			else
				kind = KIND_GOOD;
			gap = int'({28'd0, r[11:8]});
			hold_line(1'b1, gap);
			run_frame(kind, r[23:16], 1 + int'({30'd0, r[13:12]}));
		end

		@(posedge clk);
		if (seen_low != 16'hffff || seen_high != 16'hffff)
			$display("not every digit pattern was shown on both displays");
		if (dut0.asserts0.fail_count != 0)
			$display("%0d assertion failures were seen", dut0.asserts0.fail_count);
		if (seen_low == 16'hffff && seen_high == 16'hffff && dut0.asserts0.fail_count == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

// File: vlog.f
design/comtest_pkg.sv
design/digseg_driver.sv
design/uart_receiver.sv
design/comtest.sv
design/board_top.sv
sim/board_asserts.sv
sim/board_tb.sv

// File: Makefile
# Verilator build and run for the serial bring-up board

VERILATOR ?= verilator
TOP       ?= board_tb
FLIST     ?= vlog.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(wildcard design/*.sv sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when the file list or a source is newer than the binary
$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx 'TEST OK' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
